// File: filelist.f
rtl/chip8_pkg.sv
rtl/tick_divider.sv
rtl/countdown_timer.sv
rtl/chip8_regfile.sv
rtl/chip8_ram.sv
rtl/chip8_host.sv
rtl/chip8_top.sv
sim/chip8_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the Chip-8 host-control simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module chip8_tb -f filelist.f -o chip8_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/chip8_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished cleanly"
exit 0

// File: sim/chip8_tb.sv
// ##############################
// Testbench for the Chip-8 host
// control block over Wishbone
// ##############################

module chip8_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int divisor = 16;
    localparam int timeout_cycles = 3000;
    localparam int ack_limit = 8;

    logic        clk;
    logic        reset;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [4:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;
    logic        key_down;
    logic [3:0]  key_code;
    logic        sound_on;

    logic [31:0] lcg_state = 32'd19953;
    int          cycles = 0;

    chip8_top #(
        .tick_divisor (divisor)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .dat_r    (dat_r),
        .ack      (ack),
        .key_down (key_down),
        .key_code (key_code),
        .sound_on (sound_on)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit in clock cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Some tests failed");
            $fatal(1, "simulation ran past its cycle limit");
        end
    end

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
    endtask

    // One Wishbone classic cycle with ack sampled at the falling edge
    task automatic transfer(input logic write, input logic [4:0] a,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= a;
        dat_w <= wdata;
        @(negedge clk);
        while (!ack) begin
            waited++;
            if (waited >= ack_limit) begin
                $display("Bus request to address 0x%02h got no acknowledge", a);
                $display("Some tests failed");
                $fatal(1, "no acknowledge within %0d clocks", ack_limit);
            end
            @(negedge clk);
        end
        rdata = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic bus_write(input logic [4:0] a, input logic [31:0] wdata);
        logic [31:0] unused;
        transfer(1'b1, a, wdata, unused);
    endtask

    task automatic bus_read(input logic [4:0] a, output logic [31:0] rdata);
        transfer(1'b0, a, 32'h0, rdata);
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        bus_read(chip8_pkg::reg_pc, rd);
        check_value("reset_pc", 32'h200, rd);
        bus_read(chip8_pkg::reg_state, rd);
        check_value("reset_state", 32'd2, rd);
        bus_read(chip8_pkg::reg_i, rd);
        check_value("reset_i", 32'd0, rd);
        bus_read(chip8_pkg::reg_key, rd);
        check_value("reset_key", 32'd0, rd);
        bus_read(5'h13, rd);
        check_value("unmapped_13", 32'd101, rd);
        bus_read(5'h1F, rd);
        check_value("unmapped_1f", 32'd101, rd);
        @(negedge clk);
        check_value("reset_sound", 32'd0, {31'h0, sound_on});
    endtask

    task automatic test_vregs();
        logic [7:0]  vals [16];
        logic [15:0] r;
        logic [31:0] ival;
        logic [31:0] rd;
        for (int k = 0; k < 16; k++) begin
            r = next_random();
            vals[k] = r[7:0];
            // Upper bits carry noise and must be dropped
            bus_write(5'(k), {r, r[15:8], vals[k]});
        end
        ival = {next_random(), next_random()};
        bus_write(chip8_pkg::reg_i, ival);
        for (int k = 0; k < 16; k++) begin
            bus_read(5'(k), rd);
            check_value($sformatf("v%0d", k), {24'h0, vals[k]}, rd);
        end
        bus_read(chip8_pkg::reg_i, rd);
        check_value("reg_i", {16'h0, ival[15:0]}, rd);
    endtask

    task automatic test_memory();
        logic [11:0] addrs [8];
        logic [7:0]  bytes [8];
        logic [15:0] r;
        logic [31:0] rd;
        for (int k = 0; k < 8; k++) begin
            r = next_random();
            // Low bits from the index keep the addresses distinct
            addrs[k] = {r[11:3], 3'(k)};
            r = next_random();
            bytes[k] = r[7:0];
            bus_write(chip8_pkg::reg_mem, {11'h0, 1'b1, addrs[k], bytes[k]});
        end
        for (int k = 0; k < 8; k++) begin
            bus_write(chip8_pkg::reg_mem, {11'h0, 1'b0, addrs[k], 8'h00});
            bus_read(chip8_pkg::reg_mem, rd);
            check_value($sformatf("mem%0d", k), {12'h0, addrs[k], bytes[k]}, rd);
        end
        // Store bit clear only moves the latch
        bus_write(chip8_pkg::reg_mem, {11'h0, 1'b0, addrs[0], ~bytes[0]});
        bus_read(chip8_pkg::reg_mem, rd);
        check_value("mem_keep", {12'h0, addrs[0], bytes[0]}, rd);
    endtask

    task automatic test_control();
        logic [15:0] r;
        logic [31:0] rd;
        logic [3:0]  code;
        logic [1:0]  expect_state [4];
        r = next_random();
        bus_write(chip8_pkg::reg_pc, {16'hFFFF, r});
        bus_read(chip8_pkg::reg_pc, rd);
        check_value("pc", {20'h0, r[11:0]}, rd);
        r = next_random();
        bus_write(chip8_pkg::reg_key, {27'h0, r[4:0]});
        bus_read(chip8_pkg::reg_key, rd);
        check_value("key_bus", {27'h0, r[4:0]}, rd);
        // Pin change reaches the latch without a bus write
        code = ~r[3:0];
        @(posedge clk);
        key_down <= 1'b1;
        key_code <= code;
        wait_clocks(3);
        bus_read(chip8_pkg::reg_key, rd);
        check_value("key_pins", {27'h0, 1'b1, code}, rd);
        expect_state = '{2'd0, 2'd1, 2'd2, 2'd2};
        for (int s = 0; s < 4; s++) begin
            bus_write(chip8_pkg::reg_state, 32'(s));
            bus_read(chip8_pkg::reg_state, rd);
            check_value($sformatf("state%0d", s), {30'h0, expect_state[s]}, rd);
        end
    endtask

    task automatic test_timers();
        logic [15:0] r;
        logic [31:0] rd;
        logic [7:0]  load;
        logic [31:0] expected;
        logic        seen;
        bus_write(chip8_pkg::reg_delay, 32'd5);
        wait_clocks(5 * divisor + 20);
        bus_read(chip8_pkg::reg_delay, rd);
        check_value("delay_zero", 32'd0, rd);
        // Still paused after the state writes
        bus_write(chip8_pkg::reg_sound, 32'd3);
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            check_value("sound_paused", 32'd0, {31'h0, sound_on});
        end
        bus_write(chip8_pkg::reg_state, 32'd0);
        seen = 1'b0;
        for (int k = 0; k < 2 && !seen; k++) begin
            @(negedge clk);
            seen = sound_on;
        end
        check_value("sound_running", 32'd1, {31'h0, seen});
        wait_clocks(3 * divisor + 20);
        @(negedge clk);
        check_value("sound_done", 32'd0, {31'h0, sound_on});
        bus_read(chip8_pkg::reg_sound, rd);
        check_value("sound_zero", 32'd0, rd);
        r = next_random();
        load = r[7:0] | 8'h02;
        bus_write(chip8_pkg::reg_delay, {24'h0, load});
        bus_read(chip8_pkg::reg_delay, rd);
        // One tick may fall between the load and the read
        expected = {24'h0, load};
        if (rd == {24'h0, load - 8'd1}) begin
            expected = {24'h0, load - 8'd1};
        end
        check_value("delay_fresh", expected, rd);
    endtask

    initial begin
        reset    = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = 5'h00;
        dat_w    = 32'h0;
        key_down = 1'b0;
        key_code = 4'h0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_vregs();
        test_memory();
        test_control();
        test_timers();
        $display("All tests passed");
        $finish;
    end

endmodule

// File: rtl/chip8_top.sv
// ##############################
// Chip-8 host control top level
// ##############################

module chip8_top #(
    parameter int tick_divisor = 833333
) (
    input  logic                               clk,
    input  logic                               reset,
    // Wishbone classic slave
    input  logic                               cyc,
    input  logic                               stb,
    input  logic                               we,
    input  logic [chip8_pkg::adr_width-1:0]    adr,
    input  logic [chip8_pkg::data_width-1:0]   dat_w,
    output logic [chip8_pkg::data_width-1:0]   dat_r,
    output logic                               ack,
    // Keypad pins
    input  logic                               key_down,
    input  logic [3:0]                         key_code,
    output logic                               sound_on
);

    localparam int bw = chip8_pkg::byte_width;
    localparam int tc = chip8_pkg::timer_count;

    logic [3:0]                             rf_adr;
    logic                                   rf_we;
    logic [bw-1:0]                          rf_wdata;
    logic [bw-1:0]                          rf_rdata;

    logic [chip8_pkg::mem_adr_width-1:0]    mem_adr;
    logic                                   mem_we;
    logic [bw-1:0]                          mem_wdata;
    logic [bw-1:0]                          mem_rdata;

    logic                                   tick;
    logic [tc-1:0]                          timer_load;
    logic [tc-1:0][bw-1:0]                  timer_value;
    logic [tc-1:0][bw-1:0]                  timer_count_in;

    chip8_host u_host (
        .clk            (clk),
        .reset          (reset),
        .cyc            (cyc),
        .stb            (stb),
        .we             (we),
        .adr            (adr),
        .dat_w          (dat_w),
        .key_down       (key_down),
        .key_code       (key_code),
        .rf_rdata       (rf_rdata),
        .mem_rdata      (mem_rdata),
        .timer_count_in (timer_count_in),
        .dat_r          (dat_r),
        .ack            (ack),
        .rf_adr         (rf_adr),
        .rf_we          (rf_we),
        .rf_wdata       (rf_wdata),
        .mem_adr        (mem_adr),
        .mem_we         (mem_we),
        .mem_wdata      (mem_wdata),
        .timer_load     (timer_load),
        .timer_value    (timer_value),
        .sound_on       (sound_on)
    );

    chip8_regfile u_regfile (
        .clk   (clk),
        .we    (rf_we),
        .adr   (rf_adr),
        .wdata (rf_wdata),
        .rdata (rf_rdata)
    );

    chip8_ram u_ram (
        .clk   (clk),
        .we    (mem_we),
        .adr   (mem_adr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    tick_divider #(
        .divisor (tick_divisor)
    ) u_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    // Delay and sound timers share one tick
    for (genvar t = 0; t < tc; t++) begin : g_timer
        countdown_timer u_timer (
            .clk   (clk),
            .reset (reset),
            .tick  (tick),
            .load  (timer_load[t]),
            .value (timer_value[t]),
            .count (timer_count_in[t])
        );
    end

endmodule

// File: rtl/chip8_host.sv
// ##############################
// Chip-8 host block as a Wishbone slave
// Decodes the register map and holds I, PC, key and run state
// ##############################

module chip8_host (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    cyc,
    input  logic                                                    stb,
    input  logic                                                    we,
    input  logic [chip8_pkg::adr_width-1:0]                         adr,
    input  logic [chip8_pkg::data_width-1:0]                        dat_w,
    input  logic                                                    key_down,
    input  logic [3:0]                                              key_code,
    input  logic [chip8_pkg::byte_width-1:0]                        rf_rdata,
    input  logic [chip8_pkg::byte_width-1:0]                        mem_rdata,
    input  logic [chip8_pkg::timer_count-1:0][chip8_pkg::byte_width-1:0] timer_count_in,
    output logic [chip8_pkg::data_width-1:0]                        dat_r,
    output logic                                                    ack,
    output logic [3:0]                                              rf_adr,
    output logic                                                    rf_we,
    output logic [chip8_pkg::byte_width-1:0]                        rf_wdata,
    output logic [chip8_pkg::mem_adr_width-1:0]                     mem_adr,
    output logic                                                    mem_we,
    output logic [chip8_pkg::byte_width-1:0]                        mem_wdata,
    output logic [chip8_pkg::timer_count-1:0]                       timer_load,
    output logic [chip8_pkg::timer_count-1:0][chip8_pkg::byte_width-1:0] timer_value,
    output logic                                                    sound_on
);

    localparam int dw = chip8_pkg::data_width;
    localparam int aw = chip8_pkg::adr_width;
    localparam int mw = chip8_pkg::mem_adr_width;
    localparam int delay_idx = 0;
    localparam int sound_idx = 1;

    typedef enum logic [1:0] {
        bus_idle,
        bus_access,
        bus_ack
    } bus_state_e;

    bus_state_e                 bus_state;
    logic                       start;
    logic [aw-1:0]              req_adr;

    logic [15:0]                i_reg;
    logic [mw-1:0]              pc;
    logic                       key_pressed;
    logic [3:0]                 key_value;
    logic [4:0]                 key_pins_q;
    chip8_pkg::run_state_e      run_state;
    logic [mw-1:0]              mem_latch;

    // V0 to VF fill the addresses below I
    function automatic logic is_vreg(input logic [aw-1:0] a);
        return a < chip8_pkg::reg_i;
    endfunction

    // New request seen while idle
    assign start = (bus_state == bus_idle) && cyc && stb;
    assign ack = (bus_state == bus_ack);

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_state   <= bus_idle;
            rf_we       <= 1'b0;
            mem_we      <= 1'b0;
            timer_load  <= '0;
            i_reg       <= '0;
            pc          <= chip8_pkg::pc_reset;
            key_pressed <= 1'b0;
            key_value   <= '0;
            key_pins_q  <= '0;
            run_state   <= chip8_pkg::paused;
            mem_latch   <= '0;
            sound_on    <= 1'b0;
        end else begin
            // Strobes high only in the access cycle
            rf_we      <= 1'b0;
            mem_we     <= 1'b0;
            timer_load <= '0;
            key_pins_q <= {key_down, key_code};

            case (bus_state)
                bus_idle:   if (start) bus_state <= bus_access;
                bus_access: bus_state <= bus_ack;
                default:    bus_state <= bus_idle;
            endcase

            if (start && we && is_vreg(adr)) begin
                rf_we <= 1'b1;
            end

            if (start && we) begin
                case (adr)
                    chip8_pkg::reg_i:     i_reg <= dat_w[15:0];
                    chip8_pkg::reg_sound: timer_load[sound_idx] <= 1'b1;
                    chip8_pkg::reg_delay: timer_load[delay_idx] <= 1'b1;
                    chip8_pkg::reg_pc:    pc <= dat_w[mw-1:0];
                    chip8_pkg::reg_state: begin
                        case (dat_w[1:0])
                            2'd0:    run_state <= chip8_pkg::running;
                            2'd1:    run_state <= chip8_pkg::step;
                            default: run_state <= chip8_pkg::paused;
                        endcase
                    end
                    chip8_pkg::reg_mem: begin
                        mem_we    <= dat_w[20];
                        mem_latch <= dat_w[8 +: mw];
                    end
                    default: ;
                endcase
            end

            // Bus write wins over a change on the keypad pins
            if (start && we && adr == chip8_pkg::reg_key) begin
                key_pressed <= dat_w[4];
                key_value   <= dat_w[3:0];
            end else if ({key_down, key_code} != key_pins_q) begin
                key_pressed <= key_down;
                key_value   <= key_code;
            end

            // Sound needs the running state and a non-zero sound count
            sound_on <= (run_state == chip8_pkg::running) &&
                        (timer_count_in[sound_idx] != '0);
        end
    end

    // Request payload and storage addresses
    always_ff @(posedge clk) begin
        if (start) begin
            req_adr     <= adr;
            rf_adr      <= adr[3:0];
            rf_wdata    <= dat_w[chip8_pkg::byte_width-1:0];
            timer_value <= {chip8_pkg::timer_count{dat_w[chip8_pkg::byte_width-1:0]}};
            if (adr == chip8_pkg::reg_mem) begin
                mem_adr   <= we ? dat_w[8 +: mw] : mem_latch;
                mem_wdata <= dat_w[chip8_pkg::byte_width-1:0];
            end
        end
    end

    // Read data for the ack cycle
    always_comb begin
        dat_r = chip8_pkg::unmapped_read;
        if (is_vreg(req_adr)) begin
            dat_r = dw'(rf_rdata);
        end else begin
            case (req_adr)
                chip8_pkg::reg_i:     dat_r = dw'(i_reg);
                chip8_pkg::reg_sound: dat_r = dw'(timer_count_in[sound_idx]);
                chip8_pkg::reg_delay: dat_r = dw'(timer_count_in[delay_idx]);
                chip8_pkg::reg_pc:    dat_r = dw'(pc);
                chip8_pkg::reg_key:   dat_r = dw'({key_pressed, key_value});
                chip8_pkg::reg_state: dat_r = dw'(run_state);
                chip8_pkg::reg_mem:   dat_r = dw'({mem_latch, mem_rdata});
                default:              dat_r = chip8_pkg::unmapped_read;
            endcase
        end
    end

endmodule

// File: rtl/chip8_ram.sv
// ##############################
// Program memory, 4096 bytes
// ##############################

module chip8_ram (
    input  logic                                 clk,
    input  logic                                 we,
    input  logic [chip8_pkg::mem_adr_width-1:0]  adr,
    input  logic [chip8_pkg::byte_width-1:0]     wdata,
    output logic [chip8_pkg::byte_width-1:0]     rdata
);

    localparam int depth = 2 ** chip8_pkg::mem_adr_width;

    logic [chip8_pkg::byte_width-1:0] mem [depth];

    // Registered read, one clock latency
    always_ff @(posedge clk) begin
        if (we) begin
            mem[adr] <= wdata;
        end
        rdata <= mem[adr];
    end

endmodule

// File: rtl/chip8_regfile.sv
// ##############################
// V register file, 16 x 8 bits
// ##############################

module chip8_regfile (
    input  logic                              clk,
    input  logic                              we,
    input  logic [3:0]                        adr,
    input  logic [chip8_pkg::byte_width-1:0]  wdata,
    output logic [chip8_pkg::byte_width-1:0]  rdata
);

    localparam int reg_count = 16;

    logic [chip8_pkg::byte_width-1:0] regs [reg_count];

    // One port, read returns the value before a same-cycle write
    always_ff @(posedge clk) begin
        if (we) begin
            regs[adr] <= wdata;
        end
        rdata <= regs[adr];
    end

endmodule

// File: rtl/countdown_timer.sv
// ##############################
// 8-bit countdown timer, loadable
// ##############################

module countdown_timer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              tick,
    input  logic                              load,
    input  logic [chip8_pkg::byte_width-1:0]  value,
    output logic [chip8_pkg::byte_width-1:0]  count
);

    logic at_zero;

    assign at_zero = (count == '0);

    // Load beats a tick on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= value;
        end else if (tick && !at_zero) begin
            count <= count - 1'b1;
        end
    end

endmodule

// File: rtl/tick_divider.sv
// ##############################
// Timer tick, one pulse per divisor clocks
// ##############################

module tick_divider #(
    parameter int divisor = 833333
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int cnt_width = (divisor > 1) ? $clog2(divisor) : 1;

    logic [cnt_width-1:0] count;

    assign tick = (count == cnt_width'(divisor - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

// File: rtl/chip8_pkg.sv
// ##############################
// Chip-8 host control shared widths,
// register map and run states
// ##############################

package chip8_pkg;

    // Bus and storage widths
    localparam int data_width = 32;
    localparam int adr_width = 5;
    localparam int byte_width = 8;
    localparam int mem_adr_width = 12;

    // Program counter after reset
    localparam logic [mem_adr_width-1:0] pc_reset = 12'h200;

    // Read value for addresses with no register behind them
    localparam logic [data_width-1:0] unmapped_read = 32'd101;

    // Delay timer at index 0, sound timer at index 1
    parameter int timer_count = 2;

    // Host register map, V0 to VF sit at v_base + 0x0 .. 0xF
    typedef enum logic [adr_width-1:0] {
        v_base    = 5'h00,
        reg_i     = 5'h10,
        reg_sound = 5'h11,
        reg_delay = 5'h12,
        reg_pc    = 5'h14,
        reg_key   = 5'h15,
        reg_state = 5'h16,
        reg_mem   = 5'h19
    } host_reg_e;

    typedef enum logic [1:0] {
        running = 2'd0,
        step    = 2'd1,
        paused  = 2'd2
    } run_state_e;

endpackage
